//--- src.f
tcdm_pkg.sv
tcdm_if.sv
tcdm_r_valid_filter.sv
tcdm_sram_bank.sv
xfer_counter.sv
xfer_fsm.sv
apb_cfg_regs.sv
rsp_checksum.sv
tcdm_fill_top.sv
tb_tcdm_fill.sv

//--- tb_tcdm_fill.sv
// ####################################################################
// testbench for the tcdm traffic engine: apb access tasks, job table,
// reference model for checksum and count, lfsr patterns, polling
// ####################################################################

module tb_tcdm_fill import tcdm_pkg::*; ();

  localparam int NUM_ROWS  = 8;
  localparam int MAX_POLLS = 400;  // status reads before giving up

  typedef struct packed {
    addr_t     base;
    len_t      len;
    data_t     pattern;
    logic      filter_en;
    logic      rand_pat;    // take pattern from the lfsr
    logic      restart;     // second start while busy
    apb_addr_t probe_addr;
    logic      probe_err;   // expected pslverr on the probe read
  } job_row_t;

  logic      clk_i;
  logic      rst_ni;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  data_t     pwdata;
  data_t     prdata;
  logic      pready;
  logic      pslverr;
  logic      irq;

  job_row_t    rows [NUM_ROWS];
  logic [15:0] lfsr_q;
  int          irq_count;

  tcdm_fill_top u_dut (
    .clk_i, .rst_ni, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .irq
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // done pulses seen mid cycle
  always @(negedge clk_i) begin
    if (rst_ni && irq) irq_count = irq_count + 1;
  end

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output data_t w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      w      = {w[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [31:0] model_sum(input data_t pat, input len_t n,
                                            input logic filt);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < n; i++) acc = acc + pat + i;
    if (!filt) acc = acc + acc;  // write echoes carry the same words
    return acc;
  endfunction

  function automatic logic [31:0] model_count(input len_t n, input logic filt);
    return filt ? n : 2 * n;
  endfunction

  // setup phase, access phase, sample mid access
  task automatic apb_access(input logic write, input apb_addr_t addr, input data_t wdata,
                            input logic exp_err, output data_t rdata);
    @(posedge clk_i);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk_i);
    #1;
    penable = 1'b1;
    @(negedge clk_i);
    rdata = prdata;
    check_value("pready", pready, 1);
    check_value("pslverr", pslverr, exp_err);
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input data_t wdata);
    data_t unused;
    apb_access(1'b1, addr, wdata, 1'b0, unused);
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic exp_err, output data_t rdata);
    apb_access(1'b0, addr, '0, exp_err, rdata);
  endtask

  task automatic wait_idle();
    data_t st;
    int    polls;
    polls = 0;
    st    = 32'd1;
    while (st[STATUS_BUSY_BIT] && polls < MAX_POLLS) begin
      apb_read(REG_STATUS, 1'b0, st);
      polls = polls + 1;
    end
    if (st[STATUS_BUSY_BIT]) begin
      report_failure($sformatf("timeout: busy flag still set after %0d status polls",
                               polls));
    end
  endtask

  task automatic set_row(input int idx, input addr_t base, input len_t len,
                         input data_t pat, input logic filt, input logic rnd,
                         input logic restart, input apb_addr_t probe, input logic err);
    job_row_t row;
    row.base       = base;
    row.len        = len;
    row.pattern    = pat;
    row.filter_en  = filt;
    row.rand_pat   = rnd;
    row.restart    = restart;
    row.probe_addr = probe;
    row.probe_err  = err;
    rows[idx]      = row;
  endtask

  task automatic load_table();
    set_row(0, 8'h10,  9'd8,   32'h1000_0000, 1'b1, 1'b0, 1'b0, 5'h1C, 1'b1);
    set_row(1, 8'h20,  9'd8,   32'hA5A5_0000, 1'b0, 1'b0, 1'b0, 5'h14, 1'b0);
    set_row(2, 8'hF8,  9'd16,  32'h0,         1'b1, 1'b1, 1'b0, 5'h1C, 1'b1); // wraps
    set_row(3, 8'hF0,  9'd32,  32'h0,         1'b0, 1'b1, 1'b1, 5'h18, 1'b0);
    set_row(4, 8'h00,  9'd0,   32'h0000_1234, 1'b1, 1'b0, 1'b0, 5'h1C, 1'b1); // empty job
    set_row(5, 8'h40,  9'd16,  32'hFFFF_FFF8, 1'b0, 1'b0, 1'b1, 5'h1C, 1'b1);
    set_row(6, 8'h00,  9'd256, 32'h0,         1'b1, 1'b1, 1'b0, 5'h00, 1'b0);
    set_row(7, 8'h80,  9'd256, 32'h0,         1'b0, 1'b1, 1'b1, 5'h1C, 1'b1);
  endtask

  task automatic run_job(input job_row_t row);
    data_t pat;
    data_t rd;
    data_t ctrl;
    pat  = row.pattern;
    ctrl = '0;
    if (row.rand_pat) rand_word(pat);
    ctrl[CTRL_FILTER_BIT] = row.filter_en;
    ctrl[CTRL_START_BIT]  = 1'b1;
    apb_write(REG_BASE, row.base);
    apb_write(REG_LEN, row.len);
    apb_write(REG_PATTERN, pat);
    apb_read(REG_BASE, 1'b0, rd);
    check_value("base", rd, row.base);
    apb_read(REG_LEN, 1'b0, rd);
    check_value("len", rd, row.len);
    apb_read(REG_PATTERN, 1'b0, rd);
    check_value("pattern", rd, pat);
    irq_count = 0;
    apb_write(REG_CTRL, ctrl);
    apb_read(REG_STATUS, 1'b0, rd);
    if (row.len != '0) check_value("status busy", rd[STATUS_BUSY_BIT], 1);
    if (row.restart) apb_write(REG_CTRL, ctrl);  // must be ignored
    wait_idle();
    apb_read(REG_CTRL, 1'b0, rd);
    check_value("ctrl", rd, data_t'(row.filter_en) << CTRL_FILTER_BIT);  // start bit reads 0
    apb_read(REG_CHECKSUM, 1'b0, rd);
    check_value("checksum", rd, model_sum(pat, row.len, row.filter_en));
    apb_read(REG_RSP_COUNT, 1'b0, rd);
    check_value("rsp_count", rd, model_count(row.len, row.filter_en));
    check_value("irq pulses", irq_count, 1);
    apb_read(row.probe_addr, row.probe_err, rd);
  endtask

  initial begin : main_seq
    data_t rd;
    rst_ni     = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_q     = 16'd74;
    irq_count  = 0;
    load_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    apb_read(REG_STATUS, 1'b0, rd);
    check_value("status after reset", rd, 0);
    apb_read(REG_CHECKSUM, 1'b0, rd);
    check_value("checksum after reset", rd, 0);
    apb_read(REG_RSP_COUNT, 1'b0, rd);
    check_value("rsp_count after reset", rd, 0);
    check_value("irq pulses after reset", irq_count, 0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_job(rows[r]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- tcdm_fill_top.sv
// ####################################################################
// tcdm traffic engine top: apb registers, job controller, counter,
// r_valid filter, memory bank and response checksum
// ####################################################################

module tcdm_fill_top import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      irq
);

  logic   start, cfg_filter_en, job_filter_en;
  logic   busy, load, step, clear, beat_last;
  addr_t  base;
  len_t   len;
  data_t  pattern, sum;
  count_t count;

  tcdm_if tcdm_ctrl ();  // controller side of the filter
  tcdm_if tcdm_mem ();   // memory side of the filter

  apb_cfg_regs u_regs (
    .clk_i, .rst_ni, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .start, .filter_en(cfg_filter_en), .base, .len, .pattern,
    .busy, .sum, .count
  );

  xfer_fsm u_fsm (
    .clk_i, .rst_ni, .start, .filter_en_in(cfg_filter_en), .len, .pattern,
    .beat_last, .load, .step, .clear, .busy,
    .done(irq),  // done pulse doubles as interrupt
    .filter_en(job_filter_en), .tcdm(tcdm_ctrl.initiator)
  );

  xfer_counter u_cnt (
    .clk_i, .rst_ni, .load, .step, .base, .len, .beat_last,
    .tcdm(tcdm_ctrl.initiator)
  );

  tcdm_r_valid_filter u_filter (
    .clk_i, .rst_ni, .clear, .enable(job_filter_en),
    .tcdm_target(tcdm_ctrl.target), .tcdm_initiator(tcdm_mem.initiator)
  );

  tcdm_sram_bank u_mem (.clk_i, .rst_ni, .tcdm(tcdm_mem.target));

  rsp_checksum u_sum (
    .clk_i, .rst_ni, .clear, .tcdm(tcdm_ctrl.target), .sum, .count
  );

endmodule

//--- rsp_checksum.sv
// ####################################################################
// response checksum: modulo 2^32 sum of response data
// and count of valid responses
// ####################################################################

module rsp_checksum import tcdm_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear,
  tcdm_if.target tcdm,   // observes r_valid and r_data only
  output data_t  sum,
  output count_t count
);

  data_t  sum_q;
  count_t count_q;

  assign sum   = sum_q;
  assign count = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sum_q   <= '0;
      count_q <= '0;
    end else if (clear) begin
      sum_q   <= '0;  // new job
      count_q <= '0;
    end else if (tcdm.r_valid) begin
      sum_q   <= sum_q + tcdm.r_data;  // wraps
      count_q <= count_q + count_t'(1);
    end
  end

endmodule

//--- apb_cfg_regs.sv
// ####################################################################
// apb slave register file: job configuration, start pulse,
// status, checksum and response count readback
// ####################################################################

module apb_cfg_regs import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  data_t     pwdata,
  output data_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      start,
  output logic      filter_en,
  output addr_t     base,
  output len_t      len,
  output data_t     pattern,
  input  logic      busy,
  input  data_t     sum,
  input  count_t    count
);

  logic  access;
  logic  wr_en;
  logic  hit;      // offset is mapped
  logic  start_q;
  logic  filter_en_q;
  addr_t base_q;
  len_t  len_q;
  data_t pattern_q;

  assign access    = psel & penable;
  assign wr_en     = access & pwrite;
  assign pready    = 1'b1;  // zero wait states
  assign pslverr   = access & ~hit;
  assign start     = start_q;
  assign filter_en = filter_en_q;
  assign base      = base_q;
  assign len       = len_q;
  assign pattern   = pattern_q;

  // read mux and address decode
  always_comb begin
    hit    = 1'b1;
    prdata = '0;
    unique case (paddr)
      REG_CTRL:      prdata[CTRL_FILTER_BIT] = filter_en_q;  // start reads 0
      REG_BASE:      prdata = data_t'(base_q);
      REG_LEN:       prdata = data_t'(len_q);
      REG_PATTERN:   prdata = pattern_q;
      REG_STATUS:    prdata[STATUS_BUSY_BIT] = busy;
      REG_CHECKSUM:  prdata = sum;
      REG_RSP_COUNT: prdata = data_t'(count);
      default:       hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q     <= 1'b0;
      filter_en_q <= 1'b0;
      base_q      <= '0;
      len_q       <= '0;
      pattern_q   <= '0;
    end else begin
      start_q <= wr_en && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT]
                 && !busy && !start_q;  // one cycle pulse, only when idle
      if (wr_en) begin
        unique case (paddr)
          REG_CTRL:    filter_en_q <= pwdata[CTRL_FILTER_BIT];
          REG_BASE:    base_q      <= pwdata[$bits(addr_t)-1:0];
          REG_LEN:     len_q       <= pwdata[$bits(len_t)-1:0];
          REG_PATTERN: pattern_q   <= pwdata;
          default:     ;  // read-only or unmapped
        endcase
      end
    end
  end

  // controller must be idle whenever it sees start
  a_start_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start |-> !busy
  );

endmodule

//--- xfer_fsm.sv
// ####################################################################
// job controller: idle, write phase, read phase, drain, done
// drives the tcdm request fields except the address
// ####################################################################

module xfer_fsm import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start,
  input  logic      filter_en_in,
  input  len_t      len,
  input  data_t     pattern,
  input  logic      beat_last,
  output logic      load,
  output logic      step,
  output logic      clear,
  output logic      busy,
  output logic      done,
  output logic      filter_en,
  tcdm_if.initiator tcdm
);

  fsm_state_e state_q, state_d;
  len_t       idx_q;        // beat index within the phase
  logic       filter_en_q;  // held for the whole job
  logic       start_ok;

  assign start_ok  = (state_q == ST_IDLE) && start;  // start while busy dropped
  assign tcdm.req  = (state_q == ST_WRITE) || (state_q == ST_READ);
  assign tcdm.wen  = (state_q != ST_WRITE);
  assign tcdm.data = pattern + data_t'(idx_q);
  assign tcdm.be   = '1;
  assign step      = tcdm.req && tcdm.gnt;
  assign load      = start_ok || ((state_q == ST_WRITE) && step && beat_last);
  assign clear     = start_ok;
  assign busy      = (state_q != ST_IDLE);
  assign done      = (state_q == ST_DONE);
  assign filter_en = filter_en_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = (len == '0) ? ST_DRAIN : ST_WRITE;  // empty job skips phases
        end
      end
      ST_WRITE: if (step && beat_last) state_d = ST_READ;
      ST_READ:  if (step && beat_last) state_d = ST_DRAIN;
      ST_DRAIN: state_d = ST_DONE;  // last response lands here
      ST_DONE:  state_d = ST_IDLE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      idx_q       <= '0;
      filter_en_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        filter_en_q <= filter_en_in;
      end
      if (load) begin
        idx_q <= '0;  // restart index per phase
      end else if (step) begin
        idx_q <= idx_q + len_t'(1);
      end
    end
  end

  // nothing still in flight once the job is over
  a_idle_no_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == ST_IDLE) |-> !tcdm.r_valid
  );

  // last read response arrives in the drain cycle
  a_drain_last_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((state_q == ST_DRAIN) && ($past(state_q) == ST_READ)) |-> tcdm.r_valid
  );

endmodule

//--- xfer_counter.sv
// ####################################################################
// address and beat counter for one phase of a job
// drives the word address of the controller's tcdm port
// ####################################################################

module xfer_counter import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      load,
  input  logic      step,
  input  addr_t     base,
  input  len_t      len,
  output logic      beat_last,
  tcdm_if.initiator tcdm
);

  addr_t addr_q;
  len_t  remain_q;  // beats still to issue in this phase

  assign tcdm.add  = addr_q;
  assign beat_last = (remain_q == len_t'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q   <= '0;
      remain_q <= '0;
    end else if (load) begin
      addr_q   <= base;  // load wins over a step in the same cycle
      remain_q <= len;
    end else if (step) begin
      addr_q   <= addr_q + addr_t'(1);  // wraps at MEM_WORDS
      remain_q <= remain_q - len_t'(1);
    end
  end

  // controller must stop stepping when the phase is exhausted
  a_no_step_past_end : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (step && !load) |-> (remain_q != '0)
  );

endmodule

//--- tcdm_sram_bank.sv
// ####################################################################
// single bank word memory, tcdm target
// always grants, response one cycle after the request
// ####################################################################

module tcdm_sram_bank import tcdm_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  tcdm_if.target tcdm
);

  data_t mem_q [MEM_WORDS];
  logic  r_valid_q;
  data_t r_data_q;

  assign tcdm.gnt     = 1'b1;  // no stalls, single initiator
  assign tcdm.r_valid = r_valid_q;
  assign tcdm.r_data  = r_data_q;

  // storage array, byte lane writes
  always_ff @(posedge clk_i) begin
    if (tcdm.req && !tcdm.wen) begin
      for (int b = 0; b < BE_W; b++) begin
        if (tcdm.be[b]) begin
          mem_q[tcdm.add][8*b +: 8] <= tcdm.data[8*b +: 8];
        end
      end
    end
  end

  // every request gets a response next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
    end else begin
      r_valid_q <= tcdm.req & tcdm.gnt;
      if (tcdm.req) begin
        r_data_q <= tcdm.wen ? mem_q[tcdm.add]  // read data
                             : tcdm.data;       // echo of written data
      end
    end
  end

endmodule

//--- tcdm_r_valid_filter.sv
// ####################################################################
// tcdm response valid filter
// forwards the bus unchanged, optionally hides write responses
// ####################################################################

module tcdm_r_valid_filter import tcdm_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear,
  input  logic            enable,
  tcdm_if.target          tcdm_target,
  tcdm_if.initiator       tcdm_initiator
);

  logic wen_q;  // wen of the request now being answered

  // request path straight through
  assign tcdm_initiator.req  = tcdm_target.req;
  assign tcdm_initiator.wen  = tcdm_target.wen;
  assign tcdm_initiator.add  = tcdm_target.add;
  assign tcdm_initiator.data = tcdm_target.data;
  assign tcdm_initiator.be   = tcdm_target.be;

  // response path, valid masked for writes when enabled
  assign tcdm_target.gnt     = tcdm_initiator.gnt;
  assign tcdm_target.r_data  = tcdm_initiator.r_data;
  assign tcdm_target.r_valid = enable ? (tcdm_initiator.r_valid & wen_q)
                                      : tcdm_initiator.r_valid;

  // relies on exactly one cycle from grant to response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wen_q <= 1'b0;
    end else if (clear) begin
      wen_q <= 1'b0;
    end else if (tcdm_target.req && tcdm_target.gnt) begin
      wen_q <= tcdm_target.wen;  // record accepted transaction type
    end
  end

  // a granted write must never show up as a response upstream
  a_no_write_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (enable && tcdm_target.req && tcdm_target.gnt && !tcdm_target.wen)
      |=> !tcdm_target.r_valid
  );

endmodule

//--- tcdm_if.sv
// ####################################################################
// tcdm request/response bundle, single word port without sidebands
// initiator and target modports
// ####################################################################

interface tcdm_if import tcdm_pkg::*; ();

  logic  req;
  logic  wen;      // 1 = read, 0 = write
  addr_t add;      // word address
  data_t data;
  be_t   be;
  logic  gnt;
  logic  r_valid;  // one cycle after req & gnt
  data_t r_data;

  modport initiator (
    output req, wen, add, data, be,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, wen, add, data, be,
    output gnt, r_valid, r_data
  );

endinterface

//--- tcdm_pkg.sv
// ####################################################################
// shared definitions of the tcdm traffic engine: widths, typedefs,
// apb register map and the controller state encoding
// ####################################################################

package tcdm_pkg;

  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned ADDR_W     = 8;   // word address, log2(MEM_WORDS)
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned LEN_W      = 9;   // 0..256 words
  localparam int unsigned COUNT_W    = 10;  // up to 2x max length
  localparam int unsigned APB_ADDR_W = 5;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [LEN_W-1:0]      len_t;
  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;

  // apb register map, byte offsets
  localparam apb_addr_t REG_CTRL      = 5'h00;
  localparam apb_addr_t REG_BASE      = 5'h04;
  localparam apb_addr_t REG_LEN       = 5'h08;
  localparam apb_addr_t REG_PATTERN   = 5'h0C;
  localparam apb_addr_t REG_STATUS    = 5'h10;
  localparam apb_addr_t REG_CHECKSUM  = 5'h14;
  localparam apb_addr_t REG_RSP_COUNT = 5'h18;

  // bit positions inside CTRL and STATUS
  localparam int unsigned CTRL_START_BIT  = 0;  // write-only, self clearing
  localparam int unsigned CTRL_FILTER_BIT = 1;
  localparam int unsigned STATUS_BUSY_BIT = 0;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_DRAIN,  // wait for last read response
    ST_DONE
  } fsm_state_e;

endpackage
